//--- logic/sprite_pkg.sv
package sprite_pkg;

    // number of hardware sprites on the chip
    parameter int num_sprites = 8;

    // sprite x reaches the comparator two pixels late, as the chip does it,
    // so that x register writes split between the right pixels
    parameter int x_delay = 2;

    // the decoded sprite pixel is held back six pixels so that it lands on
    // the same pixel as the graphics pipeline output
    parameter int pixel_delay = 6;

    // width of the beam x position and of the sprite x coordinate
    parameter int x_width = 9;

    // one sprite row is three bytes of pixel data
    parameter int row_bits = 24;

    // sprite number as carried on the load port
    typedef logic [2:0] sprite_idx_t;

    // 2-bit pixel code, 0 is transparent
    // in single colour mode the data bit sits in the top bit and the low bit is 0
    typedef logic [1:0] pix_code_t;

    // per-sprite register settings, 13 bits
    typedef struct packed {
        logic [x_width-1:0] x;
        logic               en;
        logic               xe;
        logic               mmc;
        logic               pri;
    } sprite_cfg_t;

    // one byte of row data for the addressed sprite, 12 bits
    typedef struct packed {
        logic        valid;
        sprite_idx_t idx;
        logic [7:0]  data;
    } sprite_load_t;

    // decoded pixel with the mode bits that belong to it, 4 bits
    typedef struct packed {
        pix_code_t code;
        logic      mmc;
        logic      pri;
    } sprite_pix_t;

endpackage

//--- logic/pixel_delay_line.sv
`timescale 1ns/100ps

module pixel_delay_line #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk_dot4x,
    input  logic     rst,
    input  logic     dot_tick_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // one register stage per pixel of delay
    payload_t stage_q [depth];

    // the chain only moves on a pixel boundary and holds its contents
    // for the other three clk_dot4x cycles of the pixel
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // all-zero payload means transparent pixels and x of 0
            for (int i = 0; i < depth; i++) begin
                stage_q[i] <= '0;
            end
        end else if (dot_tick_i) begin
            stage_q[0] <= d_i;
            for (int i = 1; i < depth; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // the last stage is exactly depth pixels behind the input
    assign q_o = stage_q[depth-1];

    // a zero depth would leave the output without a register behind it
    initial begin
        if (depth < 1) begin
            $fatal(1, "pixel_delay_line needs a depth of at least one stage");
        end
    end

endmodule

//--- logic/sprite_shifter.sv
`timescale 1ns/100ps

module sprite_shifter (
    input  logic                              clk_dot4x,
    input  logic                              rst,
    input  logic                              dot_tick_i,
    input  logic [sprite_pkg::x_width-1:0]    xpos_i,
    input  logic [sprite_pkg::x_width-1:0]    x_dly_i,
    input  sprite_pkg::sprite_cfg_t           cfg_i,
    input  logic                              load_i,
    input  logic [7:0]                        data_i,
    output sprite_pkg::sprite_pix_t           pix_o
);

    // row data, the top bit is the next pixel to come out
    logic [sprite_pkg::row_bits-1:0] row_q;

    // counts row bytes, three of them make a full row
    logic [1:0] load_cnt_q;
    logic       loaded;

    // shifter state while a row is being drawn
    logic       active_q;
    logic       xe_ff_q;
    logic       mmc_ff_q;
    logic [5:0] pix_cnt_q;
    logic [5:0] last_pix;
    logic       start;
    logic       shift_step;

    sprite_pkg::pix_code_t code_next;

    assign loaded = (load_cnt_q == 2'd3);

    // a row is 24 pixels wide, or 48 when each pixel is doubled
    assign last_pix = cfg_i.xe ? 6'(2 * sprite_pkg::row_bits - 1)
                               : 6'(sprite_pkg::row_bits - 1);

    // the beam has reached the delayed x of an enabled sprite with a full row
    assign start = dot_tick_i && !active_q && cfg_i.en && loaded && (xpos_i == x_dly_i);

    // with expansion the register only moves on every second pixel
    assign shift_step = dot_tick_i && active_q && xe_ff_q;

    // pixel decode for the current shift step
    always_comb begin
        code_next = pix_o.code;
        if (xe_ff_q) begin
            if (cfg_i.mmc) begin
                // a bit pair is picked up on every second shift step and
                // held for the step in between
                if (mmc_ff_q) begin
                    code_next = row_q[sprite_pkg::row_bits-1 -: 2];
                end
            end else begin
                code_next = {row_q[sprite_pkg::row_bits-1], 1'b0};
            end
        end
    end

    // row register takes bytes in at the low end and shifts out at the top
    always_ff @(posedge clk_dot4x) begin
        if (load_i) begin
            row_q <= {row_q[sprite_pkg::row_bits-9:0], data_i};
        end else if (shift_step) begin
            row_q <= {row_q[sprite_pkg::row_bits-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active_q   <= 1'b0;
            load_cnt_q <= 2'd0;
            xe_ff_q    <= 1'b1;
            mmc_ff_q   <= 1'b1;
            pix_cnt_q  <= 6'd0;
            pix_o      <= '0;
        end else begin
            if (load_i && !loaded) begin
                load_cnt_q <= load_cnt_q + 2'd1;
            end

            if (start) begin
                // first pixel is decoded on the next tick
                active_q  <= 1'b1;
                xe_ff_q   <= 1'b1;
                mmc_ff_q  <= 1'b1;
                pix_cnt_q <= 6'd0;
                pix_o     <= '0;
            end else if (dot_tick_i && active_q) begin
                pix_o.code <= code_next;
                pix_o.mmc  <= cfg_i.mmc;
                pix_o.pri  <= cfg_i.pri;

                // the pair toggle only runs on steps that actually shift
                if (xe_ff_q && cfg_i.mmc) begin
                    mmc_ff_q <= !mmc_ff_q;
                end
                xe_ff_q <= cfg_i.xe ? !xe_ff_q : 1'b1;

                pix_cnt_q <= pix_cnt_q + 6'd1;
                // the row is used up, a fresh one has to be loaded
                // before this sprite shows again
                if (pix_cnt_q >= last_pix) begin
                    active_q   <= 1'b0;
                    load_cnt_q <= 2'd0;
                end
            end else if (dot_tick_i) begin
                pix_o <= '0;
            end
        end
    end

    // the loader must not touch a row that is still being drawn
    load_while_active: assert property (
        @(posedge clk_dot4x) disable iff (rst) load_i |-> !active_q
    ) else $error("row byte loaded while sprite shifter is drawing");

endmodule

//--- logic/collision_detect.sv
`timescale 1ns/100ps

module collision_detect #(
    parameter int num_sprites = 8
) (
    input  logic                                     clk_dot4x,
    input  logic                                     rst,
    input  logic                                     dot_tick_i,
    input  sprite_pkg::sprite_pix_t [num_sprites-1:0] pix_i,
    input  logic                                     bg_pixel_i,
    input  logic                                     m2m_clr_i,
    input  logic                                     m2d_clr_i,
    input  logic                                     m2m_irq_clr_i,
    input  logic                                     m2d_irq_clr_i,
    output logic [num_sprites-1:0]                   m2m_o,
    output logic [num_sprites-1:0]                   m2d_o,
    output logic                                     m2m_irq_o,
    output logic                                     m2d_irq_o
);

    // channel 0 is sprite-to-sprite, channel 1 is sprite-to-background
    logic [num_sprites-1:0]      m2m_hit;
    logic [num_sprites-1:0]      m2d_hit;
    logic [1:0][num_sprites-1:0] hit;
    logic [1:0]                  hit_event;
    logic [1:0]                  mask_clr;
    logic [1:0]                  irq_clr;

    logic [1:0][num_sprites-1:0] mask_q;
    logic [1:0]                  fired_q;
    logic [1:0]                  irq_q;

    always_comb begin
        for (int n = 0; n < num_sprites; n++) begin
            // only the top code bit counts against other sprites
            m2m_hit[n] = pix_i[n].code[1];
            // against the background a multicolour sprite counts on any
            // non-transparent code, single colour only on a set pixel
            if (pix_i[n].mmc) begin
                m2d_hit[n] = (pix_i[n].code != 2'b00) && bg_pixel_i;
            end else begin
                m2d_hit[n] = pix_i[n].code[1] && bg_pixel_i;
            end
        end
    end

    assign hit[0] = m2m_hit;
    assign hit[1] = m2d_hit;

    // a lone sprite cannot collide with itself, so at least two bits
    // have to be set for the m2m channel
    assign hit_event[0] = (m2m_hit & (m2m_hit - num_sprites'(1))) != '0;
    assign hit_event[1] = |m2d_hit;

    assign mask_clr = {m2d_clr_i, m2m_clr_i};
    assign irq_clr  = {m2d_irq_clr_i, m2m_irq_clr_i};

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            mask_q  <= '0;
            fired_q <= '0;
            irq_q   <= '0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (irq_clr[c]) begin
                    irq_q[c] <= 1'b0;
                end
                // clearing the mask also lets the flag fire again
                if (mask_clr[c]) begin
                    mask_q[c]  <= '0;
                    fired_q[c] <= 1'b0;
                end else if (dot_tick_i && hit_event[c]) begin
                    mask_q[c] <= mask_q[c] | hit[c];
                    // flag is raised once per mask clear
                    if (!fired_q[c]) begin
                        fired_q[c] <= 1'b1;
                        irq_q[c]   <= 1'b1;
                    end
                end
            end
        end
    end

    assign m2m_o     = mask_q[0];
    assign m2d_o     = mask_q[1];
    assign m2m_irq_o = irq_q[0];
    assign m2d_irq_o = irq_q[1];

    // a flag raised with an empty mask would point software at nothing
    m2m_irq_has_mask: assert property (
        @(posedge clk_dot4x) disable iff (rst) $rose(m2m_irq_o) |-> (m2m_o != '0)
    ) else $error("m2m interrupt raised with empty collision mask");

    m2d_irq_has_mask: assert property (
        @(posedge clk_dot4x) disable iff (rst) $rose(m2d_irq_o) |-> (m2d_o != '0)
    ) else $error("m2d interrupt raised with empty collision mask");

endmodule

//--- logic/sprite_unit.sv
`timescale 1ns/100ps

module sprite_unit #(
    parameter int num_sprites = sprite_pkg::num_sprites
) (
    input  logic                                      clk_dot4x,
    input  logic                                      rst,
    input  logic                                      dot_tick_i,
    input  logic [sprite_pkg::x_width-1:0]            xpos_i,
    input  sprite_pkg::sprite_cfg_t [num_sprites-1:0] cfg_i,
    input  sprite_pkg::sprite_load_t                  load_i,
    input  logic                                      bg_pixel_i,
    input  logic                                      m2m_clr_i,
    input  logic                                      m2d_clr_i,
    input  logic                                      m2m_irq_clr_i,
    input  logic                                      m2d_irq_clr_i,
    output sprite_pkg::sprite_pix_t [num_sprites-1:0] pix_o,
    output logic [num_sprites-1:0]                    m2m_o,
    output logic [num_sprites-1:0]                    m2d_o,
    output logic                                      m2m_irq_o,
    output logic                                      m2d_irq_o
);

    // payload shapes for the two delay lines
    typedef logic [num_sprites-1:0][sprite_pkg::x_width-1:0] x_array_t;
    typedef sprite_pkg::sprite_pix_t [num_sprites-1:0] pix_array_t;

    x_array_t               x_now;
    x_array_t               x_dly;
    logic [num_sprites-1:0] load_sel;
    pix_array_t             pix_raw;

    // pull the x fields out of the register file settings
    // and steer the load strobe to the addressed sprite
    always_comb begin
        for (int n = 0; n < num_sprites; n++) begin
            x_now[n]    = cfg_i[n].x;
            load_sel[n] = load_i.valid && (load_i.idx == sprite_pkg::sprite_idx_t'(n));
        end
    end

    // x is compared two pixels late so x splits hit the right pixel
    pixel_delay_line #(
        .depth     (sprite_pkg::x_delay),
        .payload_t (x_array_t)
    ) u_x_delay (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .d_i        (x_now),
        .q_o        (x_dly)
    );

    for (genvar n = 0; n < num_sprites; n++) begin : g_shifter
        sprite_shifter u_shifter (
            .clk_dot4x  (clk_dot4x),
            .rst        (rst),
            .dot_tick_i (dot_tick_i),
            .xpos_i     (xpos_i),
            .x_dly_i    (x_dly[n]),
            .cfg_i      (cfg_i[n]),
            .load_i     (load_sel[n]),
            .data_i     (load_i.data),
            .pix_o      (pix_raw[n])
        );
    end

    // the pixel, its mmc bit and its pri bit move together through six
    // stages so they meet the graphics pipeline on the same pixel
    pixel_delay_line #(
        .depth     (sprite_pkg::pixel_delay),
        .payload_t (pix_array_t)
    ) u_pix_delay (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .d_i        (pix_raw),
        .q_o        (pix_o)
    );

    // collisions are judged on the delayed pixels, the ones actually shown
    collision_detect #(
        .num_sprites (num_sprites)
    ) u_collision (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .dot_tick_i    (dot_tick_i),
        .pix_i         (pix_o),
        .bg_pixel_i    (bg_pixel_i),
        .m2m_clr_i     (m2m_clr_i),
        .m2d_clr_i     (m2d_clr_i),
        .m2m_irq_clr_i (m2m_irq_clr_i),
        .m2d_irq_clr_i (m2d_irq_clr_i),
        .m2m_o         (m2m_o),
        .m2d_o         (m2d_o),
        .m2m_irq_o     (m2m_irq_o),
        .m2d_irq_o     (m2d_irq_o)
    );

endmodule

//--- tb/sprite_unit_tb.sv
`timescale 1ns/100ps

module sprite_unit_tb;

    localparam int num_sprites  = sprite_pkg::num_sprites;
    localparam int sweep_end    = 384;
    localparam int tick_timeout = 16;

    logic                                      clk_dot4x;
    logic                                      rst;
    logic                                      dot_tick_i = 1'b0;
    logic [sprite_pkg::x_width-1:0]            xpos_i;
    sprite_pkg::sprite_cfg_t [num_sprites-1:0] cfg_i;
    sprite_pkg::sprite_load_t                  load_i;
    logic                                      bg_pixel_i;
    logic                                      m2m_clr_i;
    logic                                      m2d_clr_i;
    logic                                      m2m_irq_clr_i;
    logic                                      m2d_irq_clr_i;
    sprite_pkg::sprite_pix_t [num_sprites-1:0] pix_o;
    logic [num_sprites-1:0]                    m2m_o;
    logic [num_sprites-1:0]                    m2d_o;
    logic                                      m2m_irq_o;
    logic                                      m2d_irq_o;

    // free running pixel phase that gives one dot tick per four clocks
    logic [1:0] phase_q = 2'd0;

    // raw words of the stimulus file and the read position in it
    logic [31:0] stim_mem [256];
    int          ptr;

    // reference copy of the sprite settings of the current case
    logic [8:0]  spr_x   [num_sprites];
    logic        spr_en  [num_sprites];
    logic        spr_xe  [num_sprites];
    logic        spr_mmc [num_sprites];
    logic        spr_pri [num_sprites];
    logic [23:0] spr_row [num_sprites];
    logic [8:0]  bg_lo;
    logic [8:0]  bg_hi;
    logic [7:0]  exp_m2m;
    logic [7:0]  exp_m2d;

    sprite_unit #(
        .num_sprites (num_sprites)
    ) dut (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .dot_tick_i    (dot_tick_i),
        .xpos_i        (xpos_i),
        .cfg_i         (cfg_i),
        .load_i        (load_i),
        .bg_pixel_i    (bg_pixel_i),
        .m2m_clr_i     (m2m_clr_i),
        .m2d_clr_i     (m2d_clr_i),
        .m2m_irq_clr_i (m2m_irq_clr_i),
        .m2d_irq_clr_i (m2d_irq_clr_i),
        .pix_o         (pix_o),
        .m2m_o         (m2m_o),
        .m2d_o         (m2d_o),
        .m2m_irq_o     (m2m_irq_o),
        .m2d_irq_o     (m2d_irq_o)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #2 clk_dot4x = ~clk_dot4x;
    end

    always @(posedge clk_dot4x) begin
        phase_q    <= phase_q + 2'd1;
        dot_tick_i <= (phase_q == 2'd3);
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s expected %h got %h",
                                        name, expected, actual));
        end
    endtask

    // returns on the clock edge at which the DUT takes a dot tick
    task automatic wait_tick();
        int waited;
        waited = 0;
        @(posedge clk_dot4x);
        while (!dot_tick_i) begin
            waited++;
            if (waited > tick_timeout) begin
                stop_with_failure("no dot tick arrived within the timeout");
            end
            @(posedge clk_dot4x);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_dot4x);
        rst <= 1'b1;
        repeat (3) @(posedge clk_dot4x);
        rst <= 1'b0;
    endtask

    task automatic load_byte(input logic [2:0] idx, input logic [7:0] data);
        @(posedge clk_dot4x);
        load_i.valid <= 1'b1;
        load_i.idx   <= idx;
        load_i.data  <= data;
        @(posedge clk_dot4x);
        load_i.valid <= 1'b0;
    endtask

    // every sprite gets its three row bytes and the first byte ends up on top
    task automatic load_rows();
        for (int s = 0; s < num_sprites; s++) begin
            load_byte(3'(s), spr_row[s][23:16]);
            load_byte(3'(s), spr_row[s][15:8]);
            load_byte(3'(s), spr_row[s][7:0]);
        end
    endtask

    // takes one case from the word stream and drives the register file
    task automatic read_case();
        sprite_pkg::sprite_cfg_t [num_sprites-1:0] next_cfg;
        int                                        n;
        int                                        idx;
        n       = stim_mem[ptr];
        bg_lo   = stim_mem[ptr+1][8:0];
        bg_hi   = stim_mem[ptr+2][8:0];
        exp_m2m = stim_mem[ptr+3][7:0];
        exp_m2d = stim_mem[ptr+4][7:0];
        ptr     = ptr + 5;
        for (int s = 0; s < num_sprites; s++) begin
            spr_x[s]   = '0;
            spr_en[s]  = 1'b0;
            spr_xe[s]  = 1'b0;
            spr_mmc[s] = 1'b0;
            spr_pri[s] = 1'b0;
            spr_row[s] = '0;
        end
        for (int e = 0; e < n; e++) begin
            idx          = int'(stim_mem[ptr][2:0]);
            spr_x[idx]   = stim_mem[ptr+1][8:0];
            spr_en[idx]  = stim_mem[ptr+2][0];
            spr_xe[idx]  = stim_mem[ptr+3][0];
            spr_mmc[idx] = stim_mem[ptr+4][0];
            spr_pri[idx] = stim_mem[ptr+5][0];
            spr_row[idx] = stim_mem[ptr+6][23:0];
            ptr          = ptr + 7;
        end
        for (int s = 0; s < num_sprites; s++) begin
            next_cfg[s].x   = spr_x[s];
            next_cfg[s].en  = spr_en[s];
            next_cfg[s].xe  = spr_xe[s];
            next_cfg[s].mmc = spr_mmc[s];
            next_cfg[s].pri = spr_pri[s];
        end
        @(posedge clk_dot4x);
        cfg_i <= next_cfg;
    endtask

    // pixel k of a row is shown at x + 7 + k and doubled in width with xe
    // multicolour shows each bit pair for two row pixels
    function automatic sprite_pkg::sprite_pix_t expected_pixel(input int s, input int q);
        sprite_pkg::sprite_pix_t pix;
        logic [23:0]             shifted;
        int                      k;
        int                      j;
        pix = '0;
        k   = q - (int'(spr_x[s]) + sprite_pkg::pixel_delay + 1);
        j   = spr_xe[s] ? k / 2 : k;
        if (spr_en[s] && k >= 0 && j < sprite_pkg::row_bits) begin
            pix.mmc = spr_mmc[s];
            pix.pri = spr_pri[s];
            if (spr_mmc[s]) begin
                shifted  = spr_row[s] << (2 * (j / 2));
                pix.code = shifted[23:22];
            end else begin
                shifted  = spr_row[s] << j;
                pix.code = {shifted[23], 1'b0};
            end
        end
        return pix;
    endfunction

    function automatic logic pixel_on_background(input int q);
        return (q >= int'(bg_lo)) && (q <= int'(bg_hi));
    endfunction

    // one beam line from xpos 0 with every shown pixel checked
    task automatic run_sweep();
        sprite_pkg::sprite_pix_t [num_sprites-1:0] expected;
        // let the delayed x settle while the beam is parked out of range
        repeat (sprite_pkg::x_delay + 1) wait_tick();
        xpos_i <= '0;
        for (int p = 0; p < sweep_end; p++) begin
            wait_tick();
            xpos_i     <= 9'(p + 1);
            // background for the position shown after this tick
            bg_pixel_i <= pixel_on_background(p);
            @(negedge clk_dot4x);
            for (int s = 0; s < num_sprites; s++) begin
                expected[s] = expected_pixel(s, p);
            end
            check_value("pix_o", expected, pix_o);
        end
        wait_tick();
        xpos_i     <= 9'h1ff;
        bg_pixel_i <= 1'b0;
    endtask

    // a flag only comes up when it was armed by a mask clear before the line
    task automatic check_masks(input logic armed);
        wait_tick();
        @(negedge clk_dot4x);
        check_value("m2m_o", 32'(exp_m2m), 32'(m2m_o));
        check_value("m2d_o", 32'(exp_m2d), 32'(m2d_o));
        check_value("m2m_irq_o", 32'(armed && exp_m2m != '0), 32'(m2m_irq_o));
        check_value("m2d_irq_o", 32'(armed && exp_m2d != '0), 32'(m2d_irq_o));
    endtask

    // lowering only the flags leaves the masks set and the flags disarmed
    task automatic clear_irq_flags();
        @(posedge clk_dot4x);
        m2m_irq_clr_i <= 1'b1;
        m2d_irq_clr_i <= 1'b1;
        @(posedge clk_dot4x);
        m2m_irq_clr_i <= 1'b0;
        m2d_irq_clr_i <= 1'b0;
        @(negedge clk_dot4x);
        check_value("m2m_o", 32'(exp_m2m), 32'(m2m_o));
        check_value("m2d_o", 32'(exp_m2d), 32'(m2d_o));
        check_value("m2m_irq_o", 32'h0, 32'(m2m_irq_o));
        check_value("m2d_irq_o", 32'h0, 32'(m2d_irq_o));
    endtask

    // clearing both masks re-arms the flags for the next line
    task automatic clear_collisions();
        @(posedge clk_dot4x);
        m2m_clr_i     <= 1'b1;
        m2d_clr_i     <= 1'b1;
        m2m_irq_clr_i <= 1'b1;
        m2d_irq_clr_i <= 1'b1;
        @(posedge clk_dot4x);
        m2m_clr_i     <= 1'b0;
        m2d_clr_i     <= 1'b0;
        m2m_irq_clr_i <= 1'b0;
        m2d_irq_clr_i <= 1'b0;
        @(negedge clk_dot4x);
        check_value("m2m_o", 32'h0, 32'(m2m_o));
        check_value("m2d_o", 32'h0, 32'(m2d_o));
        check_value("m2m_irq_o", 32'h0, 32'(m2m_irq_o));
        check_value("m2d_irq_o", 32'h0, 32'(m2d_irq_o));
    endtask

    initial begin
        int cases;
        rst           = 1'b1;
        xpos_i        = 9'h1ff;
        cfg_i         = '0;
        load_i        = '0;
        bg_pixel_i    = 1'b0;
        m2m_clr_i     = 1'b0;
        m2d_clr_i     = 1'b0;
        m2m_irq_clr_i = 1'b0;
        m2d_irq_clr_i = 1'b0;
        cases         = 0;
        ptr           = 0;
        $readmemh("tb/sprite_stim.txt", stim_mem);
        if ($isunknown(stim_mem[0])) begin
            stop_with_failure("stimulus file tb/sprite_stim.txt could not be read");
        end
        apply_reset();
        while (ptr < 200 && stim_mem[ptr] != 32'h0) begin
            read_case();
            apply_reset();
            load_rows();
            run_sweep();
            check_masks(1'b1);
            // the same collisions again must not raise a flag while the masks stay set
            clear_irq_flags();
            load_rows();
            run_sweep();
            check_masks(1'b0);
            clear_collisions();
            // a fresh row and a further line must raise the flags again
            load_rows();
            run_sweep();
            check_masks(1'b1);
            cases++;
        end
        if (cases == 0) begin
            stop_with_failure("stimulus file holds no test cases");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- all.f
logic/sprite_pkg.sv
logic/pixel_delay_line.sv
logic/sprite_shifter.sv
logic/collision_detect.sv
logic/sprite_unit.sv
tb/sprite_unit_tb.sv

//--- run.sh
#!/bin/sh
# builds the sprite unit testbench with verilator and runs it from the project root
# the exit status is the simulator's, so a failing run returns nonzero
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps \
    --top-module sprite_unit_tb -f all.f -o sprite_unit_sim \
    && ./obj_dir/sprite_unit_sim \
    || exit 1

//--- tb/sprite_stim.txt
// case header: sprite lines, bg first x, bg last x, expected m2m mask, expected m2d mask
// sprite line: index, x, en, xe, mmc, pri, row data (24 bits), all hex
// bg is high for shown positions from first to last, first above last means never
// single colour sprite at x 20
1 1ff 000 00 00
0 014 1 0 0 0 f00faa
// expanded single colour sprite with priority set
1 1ff 000 00 00
3 040 1 1 0 1 81c3e7
// multicolour sprite, then multicolour with expansion
2 1ff 000 00 00
5 030 1 0 1 0 1b6ce4
6 090 1 1 1 1 e41b93
// sprites 1 and 2 overlap on set pixels, sprite 4 stands alone
3 1ff 000 06 00
1 050 1 0 0 0 ffffff
2 058 1 0 0 0 ff0000
4 100 1 0 0 0 ffffff
// sprites 0 and 2 over background, sprite 7 identical to 0 but over empty background
3 020 040 00 05
0 020 1 0 0 0 00ff00
2 030 1 0 1 0 400000
7 0a0 1 0 0 0 00ff00
// two disabled sprites at the same x over solid background
2 000 1ff 00 00
4 020 0 0 0 0 ffffff
5 020 0 0 0 0 ffffff
// end of cases
0
